// ==== Makefile ====
TOP := vlsu_ld_align_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlsu_ld_align.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== dv/vlsu_ld_align_sva.sv ====
// writeback credit checks
// bound into the writeback stage to check credit use, the counter bound
// and full byte masks

`timescale 1ns/1ps

module vlsu_ld_align_sva (
  input logic                                 align_clk,
  input logic                                 cpurst_b,
  input logic                                 out_vld,
  input logic [vlsu_align_pkg::LSU_BYTEW-1:0] out_bytes_vld,
  input logic                                 out_expt,
  input logic                                 out_credit,
  input logic [vlsu_align_pkg::WB_CRDW-1:0]   crd_cnt
);

  // elements sent and not yet answered by a returned credit
  logic [vlsu_align_pkg::WB_CRDW-1:0] owed;

  always_ff @(posedge align_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      owed <= '0;
    else if (out_vld && !out_credit)
      owed <= owed + 1'b1;
    else if (!out_vld && out_credit)
      owed <= owed - 1'b1;
  end

  // owed plus the last return is what the stage held when it sent
  a_no_send_without_credit: assert property (
    @(posedge align_clk) disable iff (!cpurst_b)
    out_vld |-> (owed + $past(out_credit)) < vlsu_align_pkg::WB_CREDITS
  ) else $error("element sent with no consumer credit");

  // consumer never returns more than it got
  a_credit_bound: assert property (
    @(posedge align_clk) disable iff (!cpurst_b)
    crd_cnt <= vlsu_align_pkg::WB_CREDITS
  ) else $error("credit counter above its reset value");

  a_full_mask: assert property (
    @(posedge align_clk) disable iff (!cpurst_b)
    (out_vld && !out_expt) |-> &out_bytes_vld
  ) else $error("normal element without a full byte mask");

endmodule

bind vlsu_wb_credit_stage vlsu_ld_align_sva sva0 (
  .align_clk     (align_clk),
  .cpurst_b      (cpurst_b),
  .out_vld       (out_vld),
  .out_bytes_vld (out_bytes_vld),
  .out_expt      (out_expt),
  .out_credit    (out_credit),
  .crd_cnt       (crd_cnt)
);

// ==== dv/vlsu_ld_align_tb.sv ====
// vector-load byte aligner testbench
// drives fragments under the load unit credit rule, models the consumer,
// and checks every element against a byte-stream reference model

`timescale 1ns/1ps

module vlsu_ld_align_tb;

  localparam int CLK_NS     = 8;
  localparam int SEED       = 80124;
  localparam int N1         = 6;
  localparam int N2         = 40;
  localparam int N3         = 7;
  localparam int N4         = 5;
  localparam int N5         = 10;
  localparam int FRAG_TOTAL = N1 + N2 + N3 + N4 + N5;
  localparam int WDOG_NS    = FRAG_TOTAL * 200;
  localparam int HOLD_CYC   = 80;
  // record entry kinds
  localparam int KIND_DATA  = 0;
  localparam int KIND_EXPT  = 1;
  localparam int KIND_FLUSH = 2;

  logic                                 align_clk;
  logic                                 cpurst_b;
  logic                                 in_vld;
  logic [vlsu_align_pkg::LSU_DATAW-1:0] in_data;
  logic [vlsu_align_pkg::LSU_BYTEW-1:0] in_bytes_vld;
  logic                                 in_expt;
  logic                                 in_credit;
  logic                                 flush;
  logic                                 out_vld;
  logic [vlsu_align_pkg::LSU_DATAW-1:0] out_data;
  logic [vlsu_align_pkg::LSU_BYTEW-1:0] out_bytes_vld;
  logic                                 out_expt;
  logic                                 out_credit = 1'b0;

  // byte-stream record of everything sent
  int                                   rec_kind [$];
  logic [vlsu_align_pkg::LSU_DATAW-1:0] rec_data [$];
  int                                   rec_cnt  [$];
  int                                   rec_pos  = 0;
  // open bytes of the element being built
  logic [7:0]                           open_q   [$];
  // expected elements in arrival order
  logic [vlsu_align_pkg::LSU_DATAW-1:0] exp_data [$];
  logic [vlsu_align_pkg::LSU_BYTEW-1:0] exp_mask [$];
  bit                                   exp_expt [$];

  int up_credits;
  int credit_pulses;
  int sent_total   = 0;
  int pend         = 0;
  int out_cnt      = 0;
  int err_cnt      = 0;
  int err_base     = 0;
  int n_pass       = 0;
  int n_fail       = 0;
  int hold_base    = 0;
  bit hold_credits = 1'b0;

  vlsu_ld_align_top dut0 (
    .align_clk     (align_clk),
    .cpurst_b      (cpurst_b),
    .in_vld        (in_vld),
    .in_data       (in_data),
    .in_bytes_vld  (in_bytes_vld),
    .in_expt       (in_expt),
    .in_credit     (in_credit),
    .flush         (flush),
    .out_vld       (out_vld),
    .out_data      (out_data),
    .out_bytes_vld (out_bytes_vld),
    .out_expt      (out_expt),
    .out_credit    (out_credit)
  );

  initial
  begin
    align_clk = 1'b0;
    forever #(CLK_NS / 2) align_clk = ~align_clk;
  end

  //====================================================================
  // reference model
  //====================================================================
  // low open bytes form one element with unused lanes zero
  function automatic void close_element(input bit expt);
    logic [vlsu_align_pkg::LSU_DATAW-1:0] d;
    logic [vlsu_align_pkg::LSU_BYTEW-1:0] m;
    int                                   n;
    d = '0;
    m = '0;
    n = (open_q.size() < vlsu_align_pkg::LSU_BYTEW) ? open_q.size() : vlsu_align_pkg::LSU_BYTEW;
    for (int j = 0; j < n; j++)
    begin
      d[8*j +: 8] = open_q.pop_front();
      m[j]        = 1'b1;
    end
    exp_data.push_back(d);
    exp_mask.push_back(m);
    exp_expt.push_back(expt);
  endfunction

  // walk new record entries and cut the stream into 8-byte elements
  function automatic void ref_update();
    logic [vlsu_align_pkg::LSU_DATAW-1:0] d;
    while (rec_pos < rec_kind.size())
    begin
      d = rec_data[rec_pos];
      if (rec_kind[rec_pos] == KIND_DATA)
      begin
        for (int j = 0; j < rec_cnt[rec_pos]; j++)
          open_q.push_back(d[8*j +: 8]);
        while (open_q.size() >= vlsu_align_pkg::LSU_BYTEW)
          close_element(1'b0);
      end
      else if (rec_kind[rec_pos] == KIND_EXPT)
        close_element(1'b1);
      else
        open_q.delete();
      rec_pos++;
    end
  endfunction

  function automatic logic [vlsu_align_pkg::LSU_BYTEW-1:0] bytes_mask(input int cnt);
    int m;
    m = (1 << cnt) - 1;
    return m[vlsu_align_pkg::LSU_BYTEW-1:0];
  endfunction

  //====================================================================
  // upstream and downstream models
  //====================================================================
  // load unit credit count spent by in_vld and refilled by in_credit
  always @(posedge align_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      up_credits    <= vlsu_align_pkg::FRAG_DEPTH;
      credit_pulses <= 0;
    end
    else
    begin
      up_credits    <= up_credits + int'(in_credit) - int'(in_vld);
      credit_pulses <= credit_pulses + int'(in_credit);
    end
  end

  // consumer returns each credit after a random delay
  always @(negedge align_clk)
  begin
    if (!cpurst_b)
    begin
      pend       = 0;
      out_credit = 1'b0;
    end
    else
    begin
      if (out_vld)
        pend = pend + 1;
      if (pend > 0 && !hold_credits && ($urandom % 3) == 0)
      begin
        out_credit = 1'b1;
        pend       = pend - 1;
      end
      else
        out_credit = 1'b0;
    end
  end

  //====================================================================
  // compare
  //====================================================================
  always @(negedge align_clk)
  begin
    if (cpurst_b && out_vld)
    begin
      out_cnt = out_cnt + 1;
      if (exp_data.size() == 0)
      begin
        $display("unexpected element at %0t, no element was due", $time);
        err_cnt = err_cnt + 1;
      end
      else
      begin
        if (out_data !== exp_data[0] || out_bytes_vld !== exp_mask[0] ||
            out_expt !== exp_expt[0])
        begin
          $display("MISMATCH at %0t: element %0d got %h/%b/%b exp %h/%b/%b",
                   $time, out_cnt, out_data, out_bytes_vld, out_expt,
                   exp_data[0], exp_mask[0], exp_expt[0]);
          err_cnt = err_cnt + 1;
        end
        void'(exp_data.pop_front());
        void'(exp_mask.pop_front());
        void'(exp_expt.pop_front());
      end
    end
  end

  //====================================================================
  // stimulus tasks
  //====================================================================
  // called and returns at a falling edge
  task automatic send_fragment(input int kind, input int cnt);
    logic [vlsu_align_pkg::LSU_DATAW-1:0] data;
    data = {$urandom, $urandom};
    while (up_credits == 0)
    begin
      in_vld = 1'b0;
      @(negedge align_clk);
    end
    in_vld       = 1'b1;
    in_data      = data;
    in_bytes_vld = bytes_mask(cnt);
    in_expt      = (kind == KIND_EXPT);
    rec_kind.push_back(kind);
    rec_data.push_back(data);
    rec_cnt.push_back(cnt);
    sent_total++;
    ref_update();
    @(negedge align_clk);
    in_vld  = 1'b0;
    in_expt = 1'b0;
  endtask

  // flush once every sent fragment has left the queue
  task automatic flush_idle();
    while (credit_pulses != sent_total)
      @(negedge align_clk);
    flush = 1'b1;
    rec_kind.push_back(KIND_FLUSH);
    rec_data.push_back('0);
    rec_cnt.push_back(0);
    ref_update();
    @(negedge align_clk);
    flush = 1'b0;
  endtask

  task automatic wait_drain();
    @(posedge align_clk);
    while (exp_data.size() != 0 || pend != 0)
      @(posedge align_clk);
    repeat (16) @(posedge align_clk);
    @(negedge align_clk);
  endtask

  task automatic report_test(input int num, input string name);
    if (err_cnt == err_base)
    begin
      n_pass++;
      $display("test %0d %s: pass", num, name);
    end
    else
    begin
      n_fail++;
      $display("test %0d %s: fail, %0d errors", num, name, err_cnt - err_base);
    end
    err_base = err_cnt;
  endtask

  //====================================================================
  // test sequence
  //====================================================================
  initial
  begin
    void'($urandom(SEED));
    cpurst_b     = 1'b0;
    in_vld       = 1'b0;
    in_data      = '0;
    in_bytes_vld = '0;
    in_expt      = 1'b0;
    flush        = 1'b0;
    repeat (2) @(posedge align_clk);
    @(negedge align_clk);
    cpurst_b = 1'b1;

    for (int i = 0; i < N1; i++)
      send_fragment(KIND_DATA, 8);
    wait_drain();
    report_test(1, "full fragments");

    // random sizes with idle gaps
    for (int i = 0; i < N2; i++)
    begin
      send_fragment(KIND_DATA, 1 + int'($urandom % 8));
      if (($urandom % 4) == 0)
        @(negedge align_clk);
    end
    wait_drain();
    report_test(2, "random sizes");

    // first exception closes whatever test 2 left open
    send_fragment(KIND_EXPT, 4);
    send_fragment(KIND_DATA, 3);
    send_fragment(KIND_DATA, 2);
    send_fragment(KIND_EXPT, 8);
    send_fragment(KIND_DATA, 8);
    send_fragment(KIND_DATA, 5);
    send_fragment(KIND_DATA, 3);
    wait_drain();
    report_test(3, "exception");

    send_fragment(KIND_DATA, 5);
    flush_idle();
    send_fragment(KIND_DATA, 3);
    send_fragment(KIND_DATA, 5);
    send_fragment(KIND_DATA, 8);
    send_fragment(KIND_DATA, 8);
    wait_drain();
    report_test(4, "flush");

    // consumer holds its credits and then releases them
    hold_base    = out_cnt;
    hold_credits = 1'b1;
    fork
      for (int i = 0; i < N5; i++)
        send_fragment(KIND_DATA, 8);
      begin
        repeat (HOLD_CYC) @(posedge align_clk);
        if (out_cnt - hold_base > vlsu_align_pkg::WB_CREDITS)
        begin
          $display("MISMATCH at %0t: %0d elements sent with %0d credits",
                   $time, out_cnt - hold_base, vlsu_align_pkg::WB_CREDITS);
          err_cnt++;
        end
        hold_credits = 1'b0;
      end
    join
    wait_drain();
    report_test(5, "credit hold");

    if (credit_pulses != sent_total)
    begin
      $display("MISMATCH at %0t: %0d in_credit pulses for %0d fragments",
               $time, credit_pulses, sent_total);
      err_cnt++;
    end
    report_test(6, "upstream credits");

    $display("tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, err_cnt);
    if (n_fail == 0 && err_cnt == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  // watchdog scaled by the fragment count
  initial
  begin
    #(WDOG_NS);
    $display("timeout: run still busy after %0d ns", WDOG_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== source/vlsu_align_pkg.sv ====
// vector-load byte aligner shared definitions
// widths, queue depths and credit counts for all three stages

package vlsu_align_pkg;

  //====================================================================
  // datapath widths
  //====================================================================
  // element and fragment width in bits
  localparam int LSU_DATAW  = 64;
  // byte lanes per element
  localparam int LSU_BYTEW  = 8;

  //====================================================================
  // queues and credits
  //====================================================================
  // fragment queue entries, also the load unit credits after reset
  localparam int FRAG_DEPTH = 2;
  // writeback queue entries
  localparam int WB_DEPTH   = 2;
  // credits held toward the consumer after reset
  localparam int WB_CREDITS = 4;
  // consumer credit counter width, must hold WB_CREDITS
  localparam int WB_CRDW    = 3;

endpackage

// ==== source/vlsu_ld_align_buffer.sv ====
// load align buffer
// packs contiguous byte fragments into whole elements: rotates each
// fragment onto the fill position, merges it in, carries the wrapped
// bytes into the next element, and closes a partial element on an
// exception fragment

`timescale 1ns/1ps

module vlsu_ld_align_buffer (
  input  logic                                 align_clk,
  input  logic                                 cpurst_b,
  input  logic                                 flush,
  input  logic                                 frag_vld,
  input  logic [vlsu_align_pkg::LSU_DATAW-1:0] frag_data,
  input  logic [vlsu_align_pkg::LSU_BYTEW-1:0] frag_bytes_vld,
  input  logic                                 frag_expt,
  input  logic                                 wb_space,
  output logic                                 frag_pop,
  output logic                                 elem_vld,
  output logic [vlsu_align_pkg::LSU_DATAW-1:0] elem_data,
  output logic [vlsu_align_pkg::LSU_BYTEW-1:0] elem_bytes_vld,
  output logic                                 elem_expt
);

  // partial element under construction
  logic [vlsu_align_pkg::LSU_DATAW-1:0]   data_q;
  logic [vlsu_align_pkg::LSU_BYTEW-1:0]   bytes_vld_q;
  // one-hot, points at first empty lane
  logic [vlsu_align_pkg::LSU_BYTEW-1:0]   rot_q;

  logic [2*vlsu_align_pkg::LSU_DATAW-1:0] data_dbl;
  logic [2*vlsu_align_pkg::LSU_BYTEW-1:0] bytes_dbl;
  logic [vlsu_align_pkg::LSU_DATAW-1:0]   data_aft_rot;
  logic [vlsu_align_pkg::LSU_BYTEW-1:0]   bytes_aft_rot;
  logic [vlsu_align_pkg::LSU_DATAW-1:0]   bytes_vld_ext;
  logic [vlsu_align_pkg::LSU_DATAW-1:0]   data_merge;
  logic [vlsu_align_pkg::LSU_BYTEW-1:0]   bytes_merge;
  logic                                   merge_full;
  logic [vlsu_align_pkg::LSU_DATAW-1:0]   data_next;
  logic [vlsu_align_pkg::LSU_BYTEW-1:0]   bytes_next;
  logic [vlsu_align_pkg::LSU_BYTEW-1:0]   rot_next;
  logic                                   pop_normal;
  logic                                   pop_expt;

  //====================================================================
  // pop control
  //====================================================================
  // flush wins, head stays queued for the next cycle
  // wb_space guarantees room for a completing element
  assign frag_pop   = frag_vld && wb_space && !flush;
  assign pop_normal = frag_pop && !frag_expt;
  assign pop_expt   = frag_pop && frag_expt;

  //====================================================================
  // rotate onto fill position
  //====================================================================
  // rotate left by the lane index of rot_q
  // doubled word, upper half is the rotated value
  always_comb
  begin
    data_dbl  = '0;
    bytes_dbl = '0;
    for (int k = 0; k < vlsu_align_pkg::LSU_BYTEW; k++)
    begin
      if (rot_q[k])
      begin
        data_dbl  = {frag_data, frag_data}
                    << ((vlsu_align_pkg::LSU_DATAW / vlsu_align_pkg::LSU_BYTEW) * k);
        bytes_dbl = {frag_bytes_vld, frag_bytes_vld} << k;
      end
    end
  end

  assign data_aft_rot  = data_dbl[2*vlsu_align_pkg::LSU_DATAW-1:vlsu_align_pkg::LSU_DATAW];
  assign bytes_aft_rot = bytes_dbl[2*vlsu_align_pkg::LSU_BYTEW-1:vlsu_align_pkg::LSU_BYTEW];

  //====================================================================
  // merge
  //====================================================================
  // byte mask widened to bit mask
  always_comb
  begin
    for (int i = 0; i < vlsu_align_pkg::LSU_BYTEW; i++)
    begin
      bytes_vld_ext[i*8 +: 8] = {8{bytes_vld_q[i]}};
    end
  end

  // old bytes kept, new bytes fill the empty lanes
  assign bytes_merge = bytes_aft_rot | bytes_vld_q;
  assign data_merge  = (data_q & bytes_vld_ext) | (data_aft_rot & ~bytes_vld_ext);
  assign merge_full  = &bytes_merge;

  // on completion only the wrapped bytes survive, in the low lanes
  // wrapped = rotated lanes that collide with old lanes
  assign bytes_next = merge_full ? (bytes_aft_rot & bytes_vld_q) : bytes_merge;
  assign data_next  = merge_full ? data_aft_rot : data_merge;

  // new fill position, one above highest valid lane
  // mask is contiguous from lane 0, so last hit wins
  always_comb
  begin
    rot_next    = '0;
    rot_next[0] = 1'b1;
    for (int k = 0; k < vlsu_align_pkg::LSU_BYTEW - 1; k++)
    begin
      if (bytes_next[k])
      begin
        rot_next      = '0;
        rot_next[k+1] = 1'b1;
      end
    end
  end

  //====================================================================
  // state
  //====================================================================
  always_ff @(posedge align_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      bytes_vld_q <= '0;
      rot_q       <= {{(vlsu_align_pkg::LSU_BYTEW-1){1'b0}}, 1'b1};
    end
    else if (flush || pop_expt)
    begin
      // discard partial element, restart at lane 0
      bytes_vld_q <= '0;
      rot_q       <= {{(vlsu_align_pkg::LSU_BYTEW-1){1'b0}}, 1'b1};
    end
    else if (pop_normal)
    begin
      bytes_vld_q <= bytes_next;
      rot_q       <= rot_next;
    end
  end

  // payload, qualified by bytes_vld_q
  always_ff @(posedge align_clk)
  begin
    if (pop_normal)
      data_q <= data_next;
  end

  //====================================================================
  // element out
  //====================================================================
  // completes in the same cycle as the pop
  assign elem_vld  = pop_expt || (pop_normal && merge_full);
  assign elem_expt = pop_expt;

  // exception: partial element as is, empty lanes zeroed
  assign elem_data      = frag_expt ? (data_q & bytes_vld_ext) : data_merge;
  assign elem_bytes_vld = frag_expt ? bytes_vld_q : bytes_merge;

endmodule

// ==== source/vlsu_ld_align_top.sv ====
// vector-load byte aligner top
// fragment queue -> align buffer -> writeback credit stage

`timescale 1ns/1ps

module vlsu_ld_align_top (
  input  logic                                 align_clk,
  input  logic                                 cpurst_b,
  input  logic                                 in_vld,
  input  logic [vlsu_align_pkg::LSU_DATAW-1:0] in_data,
  input  logic [vlsu_align_pkg::LSU_BYTEW-1:0] in_bytes_vld,
  input  logic                                 in_expt,
  output logic                                 in_credit,
  input  logic                                 flush,
  output logic                                 out_vld,
  output logic [vlsu_align_pkg::LSU_DATAW-1:0] out_data,
  output logic [vlsu_align_pkg::LSU_BYTEW-1:0] out_bytes_vld,
  output logic                                 out_expt,
  input  logic                                 out_credit
);

  // fragment queue head
  logic                                 frag_vld;
  logic [vlsu_align_pkg::LSU_DATAW-1:0] frag_data;
  logic [vlsu_align_pkg::LSU_BYTEW-1:0] frag_bytes_vld;
  logic                                 frag_expt;
  logic                                 frag_pop;
  // finished element
  logic                                 elem_vld;
  logic [vlsu_align_pkg::LSU_DATAW-1:0] elem_data;
  logic [vlsu_align_pkg::LSU_BYTEW-1:0] elem_bytes_vld;
  logic                                 elem_expt;
  logic                                 wb_space;

  vlsu_ld_frag_stage frag0 (
    .align_clk      (align_clk),
    .cpurst_b       (cpurst_b),
    .in_vld         (in_vld),
    .in_data        (in_data),
    .in_bytes_vld   (in_bytes_vld),
    .in_expt        (in_expt),
    .frag_pop       (frag_pop),
    .in_credit      (in_credit),
    .frag_vld       (frag_vld),
    .frag_data      (frag_data),
    .frag_bytes_vld (frag_bytes_vld),
    .frag_expt      (frag_expt)
  );

  vlsu_ld_align_buffer align0 (
    .align_clk      (align_clk),
    .cpurst_b       (cpurst_b),
    .flush          (flush),
    .frag_vld       (frag_vld),
    .frag_data      (frag_data),
    .frag_bytes_vld (frag_bytes_vld),
    .frag_expt      (frag_expt),
    .wb_space       (wb_space),
    .frag_pop       (frag_pop),
    .elem_vld       (elem_vld),
    .elem_data      (elem_data),
    .elem_bytes_vld (elem_bytes_vld),
    .elem_expt      (elem_expt)
  );

  vlsu_wb_credit_stage wb0 (
    .align_clk      (align_clk),
    .cpurst_b       (cpurst_b),
    .elem_vld       (elem_vld),
    .elem_data      (elem_data),
    .elem_bytes_vld (elem_bytes_vld),
    .elem_expt      (elem_expt),
    .out_credit     (out_credit),
    .wb_space       (wb_space),
    .out_vld        (out_vld),
    .out_data       (out_data),
    .out_bytes_vld  (out_bytes_vld),
    .out_expt       (out_expt)
  );

endmodule

// ==== source/vlsu_ld_frag_stage.sv ====
// load fragment queue
// buffers fragments from the load unit and hands the head to the
// align buffer, returning one credit upstream per entry popped

`timescale 1ns/1ps

module vlsu_ld_frag_stage (
  input  logic                                 align_clk,
  input  logic                                 cpurst_b,
  input  logic                                 in_vld,
  input  logic [vlsu_align_pkg::LSU_DATAW-1:0] in_data,
  input  logic [vlsu_align_pkg::LSU_BYTEW-1:0] in_bytes_vld,
  input  logic                                 in_expt,
  input  logic                                 frag_pop,
  output logic                                 in_credit,
  output logic                                 frag_vld,
  output logic [vlsu_align_pkg::LSU_DATAW-1:0] frag_data,
  output logic [vlsu_align_pkg::LSU_BYTEW-1:0] frag_bytes_vld,
  output logic                                 frag_expt
);

  // entry storage, payload only
  logic [vlsu_align_pkg::LSU_DATAW-1:0] q_data  [vlsu_align_pkg::FRAG_DEPTH];
  logic [vlsu_align_pkg::LSU_BYTEW-1:0] q_bytes [vlsu_align_pkg::FRAG_DEPTH];
  logic                                 q_expt  [vlsu_align_pkg::FRAG_DEPTH];

  logic [$clog2(vlsu_align_pkg::FRAG_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(vlsu_align_pkg::FRAG_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(vlsu_align_pkg::FRAG_DEPTH+1)-1:0] q_cnt;

  //====================================================================
  // pointers and occupancy
  //====================================================================
  // no full check, the load unit never sends without a credit
  always_ff @(posedge align_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      q_cnt     <= '0;
      in_credit <= 1'b0;
    end
    else
    begin
      if (in_vld)
        wr_ptr <= (wr_ptr == vlsu_align_pkg::FRAG_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      if (frag_pop)
        rd_ptr <= (rd_ptr == vlsu_align_pkg::FRAG_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      // push and pop together leave count alone
      if (in_vld && !frag_pop)
        q_cnt <= q_cnt + 1'b1;
      else if (!in_vld && frag_pop)
        q_cnt <= q_cnt - 1'b1;
      // one credit back per entry gone, a cycle after the pop
      in_credit <= frag_pop;
    end
  end

  // write side
  always_ff @(posedge align_clk)
  begin
    if (in_vld)
    begin
      q_data[wr_ptr]  <= in_data;
      q_bytes[wr_ptr] <= in_bytes_vld;
      q_expt[wr_ptr]  <= in_expt;
    end
  end

  //====================================================================
  // head entry to align buffer
  //====================================================================
  assign frag_vld       = (q_cnt != '0);
  assign frag_data      = q_data[rd_ptr];
  assign frag_bytes_vld = q_bytes[rd_ptr];
  assign frag_expt      = q_expt[rd_ptr];

endmodule

// ==== source/vlsu_wb_credit_stage.sv ====
// writeback credit stage
// queues finished elements and sends one per cycle to the consumer
// while a credit is held; returned credits refill the counter

`timescale 1ns/1ps

module vlsu_wb_credit_stage (
  input  logic                                 align_clk,
  input  logic                                 cpurst_b,
  input  logic                                 elem_vld,
  input  logic [vlsu_align_pkg::LSU_DATAW-1:0] elem_data,
  input  logic [vlsu_align_pkg::LSU_BYTEW-1:0] elem_bytes_vld,
  input  logic                                 elem_expt,
  input  logic                                 out_credit,
  output logic                                 wb_space,
  output logic                                 out_vld,
  output logic [vlsu_align_pkg::LSU_DATAW-1:0] out_data,
  output logic [vlsu_align_pkg::LSU_BYTEW-1:0] out_bytes_vld,
  output logic                                 out_expt
);

  logic [vlsu_align_pkg::LSU_DATAW-1:0] q_data  [vlsu_align_pkg::WB_DEPTH];
  logic [vlsu_align_pkg::LSU_BYTEW-1:0] q_bytes [vlsu_align_pkg::WB_DEPTH];
  logic                                 q_expt  [vlsu_align_pkg::WB_DEPTH];

  logic [$clog2(vlsu_align_pkg::WB_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(vlsu_align_pkg::WB_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(vlsu_align_pkg::WB_DEPTH+1)-1:0] q_cnt;
  logic [vlsu_align_pkg::WB_CRDW-1:0]            crd_cnt;

  logic q_nonempty;
  logic send;
  logic bypass;
  logic push;
  logic pop;

  //====================================================================
  // send decision
  //====================================================================
  assign q_nonempty = (q_cnt != '0);
  // empty queue lets a new element go straight to the output regs
  assign send       = (crd_cnt != '0) && (q_nonempty || elem_vld);
  assign bypass     = send && !q_nonempty;
  assign push       = elem_vld && !bypass;
  assign pop        = send && q_nonempty;
  assign wb_space   = (q_cnt < vlsu_align_pkg::WB_DEPTH);

  //====================================================================
  // queue and credit counter
  //====================================================================
  always_ff @(posedge align_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_cnt   <= '0;
      crd_cnt <= vlsu_align_pkg::WB_CRDW'(vlsu_align_pkg::WB_CREDITS);
      out_vld <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == vlsu_align_pkg::WB_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == vlsu_align_pkg::WB_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      if (push && !pop)
        q_cnt <= q_cnt + 1'b1;
      else if (!push && pop)
        q_cnt <= q_cnt - 1'b1;
      // send and return together cancel out
      if (send && !out_credit)
        crd_cnt <= crd_cnt - 1'b1;
      else if (!send && out_credit)
        crd_cnt <= crd_cnt + 1'b1;
      out_vld <= send;
    end
  end

  always_ff @(posedge align_clk)
  begin
    if (push)
    begin
      q_data[wr_ptr]  <= elem_data;
      q_bytes[wr_ptr] <= elem_bytes_vld;
      q_expt[wr_ptr]  <= elem_expt;
    end
  end

  // output payload, head first, else the bypassed element
  always_ff @(posedge align_clk)
  begin
    if (send)
    begin
      out_data      <= q_nonempty ? q_data[rd_ptr]  : elem_data;
      out_bytes_vld <= q_nonempty ? q_bytes[rd_ptr] : elem_bytes_vld;
      out_expt      <= q_nonempty ? q_expt[rd_ptr]  : elem_expt;
    end
  end

endmodule

// ==== vlsu_ld_align.f ====
source/vlsu_align_pkg.sv
source/vlsu_ld_frag_stage.sv
source/vlsu_ld_align_buffer.sv
source/vlsu_wb_credit_stage.sv
source/vlsu_ld_align_top.sv
dv/vlsu_ld_align_sva.sv
dv/vlsu_ld_align_tb.sv
